/* miq_defs.svh */
`ifndef MIQ_DEFS_SVH
`define MIQ_DEFS_SVH

// Width of one data word in bits
`define MIQ_DATA_WIDTH 16

// Queue capacity in words
// Must stay a power of two, the pointers rely on natural wrap
`define MIQ_DEPTH 16

// Producer lanes offered per clock
`define MIQ_LANES 4

`endif

/* miq_pkg.sv */
`include "miq_defs.svh"

package miq_pkg;

    // One data word
    typedef logic [`MIQ_DATA_WIDTH-1:0] data_t;

    // One bit per producer lane
    typedef logic [`MIQ_LANES-1:0] lane_mask_t;

    // All lane words side by side, lane 0 in the low bits
    typedef logic [`MIQ_LANES*`MIQ_DATA_WIDTH-1:0] lane_bus_t;

    // Words moved in one cycle, 0 to MIQ_LANES
    typedef logic [$clog2(`MIQ_LANES+1)-1:0] lane_cnt_t;

    // Buffer index, wraps at MIQ_DEPTH
    typedef logic [$clog2(`MIQ_DEPTH)-1:0] ptr_t;

    // Occupancy or free space, 0 to MIQ_DEPTH
    typedef logic [$clog2(`MIQ_DEPTH+1)-1:0] occ_t;

endpackage

/* lane_packer.sv */
`timescale 1ns/1ps
`include "miq_defs.svh"

// Compacts the accepted lanes into a dense, lane-ordered group of words
module lane_packer (
    input  miq_pkg::lane_mask_t lane_valid,
    input  miq_pkg::lane_bus_t  lane_data,
    input  miq_pkg::occ_t       free_slots,
    output miq_pkg::lane_mask_t lane_ready,
    output miq_pkg::lane_bus_t  wr_data,
    output miq_pkg::lane_cnt_t  wr_count
);

    import miq_pkg::*;

    lane_mask_t accept;                  // Valid and ready this cycle
    lane_cnt_t  prefix [`MIQ_LANES+1];   // Accepted lanes below each index

    // Lane g may go only if there is room for g+1 words.
    // Readiness looks at free space alone, never at valid.
    genvar g;
    generate
        for (g = 0; g < `MIQ_LANES; g++) begin : g_ready
            assign lane_ready[g] = (g < free_slots);
        end
    endgenerate

    assign accept = lane_valid & lane_ready;

    // Running count of accepted lanes
    always_comb begin
        prefix[0] = '0;
        for (int i = 0; i < `MIQ_LANES; i++) begin
            prefix[i+1] = prefix[i] + lane_cnt_t'(accept[i]);
        end
    end

    assign wr_count = prefix[`MIQ_LANES];

    // Each accepted lane lands in the slot given by its prefix count,
    // so skipped lanes leave no hole in the packed group
    always_comb begin
        wr_data = '0;                    // Slots above wr_count are unused
        for (int i = 0; i < `MIQ_LANES; i++) begin
            if (accept[i]) begin
                wr_data[prefix[i]*`MIQ_DATA_WIDTH +: `MIQ_DATA_WIDTH] =
                    lane_data[i*`MIQ_DATA_WIDTH +: `MIQ_DATA_WIDTH];
            end
        end
    end

endmodule

/* insert_queue.sv */
`timescale 1ns/1ps
`include "miq_defs.svh"

// Circular buffer taking up to MIQ_LANES packed words per cycle, one out
module insert_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  miq_pkg::lane_bus_t  wr_data,
    input  miq_pkg::lane_cnt_t  wr_count,
    input  logic                pop,
    output miq_pkg::data_t      pop_data,
    output miq_pkg::occ_t       free_slots,
    output logic                full,
    output logic                empty,
    output miq_pkg::occ_t       occupancy
);

    import miq_pkg::*;

    data_t mem [`MIQ_DEPTH];             // Word storage

    ptr_t  head;                         // Oldest word
    ptr_t  tail;                         // Next free slot
    occ_t  count;                        // Words held

    ptr_t  wr_addr [`MIQ_LANES];         // Wrapped address per packed slot
    logic  pop_en;                       // Pop that actually removes a word
    occ_t  next_count;

    // Status straight from registered state
    assign empty      = (count == '0);
    assign full       = (count == occ_t'(`MIQ_DEPTH));
    assign occupancy  = count;
    assign free_slots = occ_t'(`MIQ_DEPTH) - count;
    assign pop_data   = mem[head];

    // Pop on empty is simply ignored
    assign pop_en = pop && !empty;

    // Writes and pop folded into a single count update
    assign next_count = count + occ_t'(wr_count) - occ_t'(pop_en);

    genvar g;
    generate
        for (g = 0; g < `MIQ_LANES; g++) begin : g_addr
            assign wr_addr[g] = tail + ptr_t'(g);   // Wraps at depth
        end
    endgenerate

    // Slot i goes to tail+i when it is part of this group
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MIQ_LANES; i++) begin
            if (i < wr_count) begin
                mem[wr_addr[i]] <= wr_data[i*`MIQ_DATA_WIDTH +: `MIQ_DATA_WIDTH];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + ptr_t'(wr_count);
            count <= next_count;
            if (pop_en) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule

/* multi_insert_queue_top.sv */
`timescale 1ns/1ps
`include "miq_defs.svh"

// Multi-lane collection queue, packer in front of the circular buffer
module multi_insert_queue_top (
    input  logic                clk,
    input  logic                rst_n,
    input  miq_pkg::lane_mask_t lane_valid,
    input  miq_pkg::lane_bus_t  lane_data,
    output miq_pkg::lane_mask_t lane_ready,
    input  logic                pop,
    output miq_pkg::data_t      pop_data,
    output logic                full,
    output logic                empty,
    output miq_pkg::occ_t       occupancy
);

    import miq_pkg::*;

    lane_bus_t wr_data;                  // Packed words, slot 0 first
    lane_cnt_t wr_count;                 // Words in this group
    occ_t      free_slots;               // Room left before this edge

    // Combinational, no latency through here
    lane_packer u_packer (
        .lane_valid (lane_valid),
        .lane_data  (lane_data),
        .free_slots (free_slots),
        .lane_ready (lane_ready),
        .wr_data    (wr_data),
        .wr_count   (wr_count)
    );

    // One edge from write or pop to status
    insert_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_data    (wr_data),
        .wr_count   (wr_count),
        .pop        (pop),
        .pop_data   (pop_data),
        .free_slots (free_slots),
        .full       (full),
        .empty      (empty),
        .occupancy  (occupancy)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

// Free-running testbench clock and power-on reset
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 10;     // 20 ns clock
    localparam int RESET_CYCLES = 5;
    localparam int RELEASE_DELAY = 2;    // Same offset as the stimulus

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RELEASE_DELAY) rst_n = 1'b1;
    end

endmodule

/* multi_insert_queue_chk.sv */
`timescale 1ns/1ps
`include "miq_defs.svh"

// Status invariants of the collection queue, bound into the top level
module multi_insert_queue_chk (
    input logic                clk,
    input logic                rst_n,
    input miq_pkg::lane_mask_t lane_ready,
    input logic                full,
    input logic                empty,
    input miq_pkg::occ_t       occupancy
);

    import miq_pkg::*;

    int fail_count = 0;                  // Assertion failures so far

    a_full_empty_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(full && empty)
    ) else begin
        fail_count++;
        $error("full and empty are high in the same cycle");
    end

    // Occupancy can never pass the buffer size
    a_occ_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) occupancy <= occ_t'(`MIQ_DEPTH)
    ) else begin
        fail_count++;
        $error("occupancy %0d is above the queue depth", occupancy);
    end

    a_no_ready_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) full |-> (lane_ready == '0)
    ) else begin
        fail_count++;
        $error("lane_ready is %b while the queue is full", lane_ready);
    end

    a_empty_vs_occ: assert property (
        @(posedge clk) disable iff (!rst_n) empty == (occupancy == '0)
    ) else begin
        fail_count++;
        $error("empty disagrees with occupancy %0d", occupancy);
    end

endmodule

bind multi_insert_queue_top multi_insert_queue_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_ready (lane_ready),
    .full       (full),
    .empty      (empty),
    .occupancy  (occupancy)
);

/* multi_insert_queue_tb.sv */
`timescale 1ns/1ps
`include "miq_defs.svh"

module multi_insert_queue_tb;

    import miq_pkg::*;

    localparam int LANES       = `MIQ_LANES;
    localparam int DEPTH       = `MIQ_DEPTH;
    localparam int WIDTH       = `MIQ_DATA_WIDTH;
    localparam int N_ROWS      = 18;
    localparam int DRIVE_DELAY = 2;      // ns after the rising edge
    localparam int TIMEOUT_PAD = 50;

    // One table row, applied for reps cycles
    typedef struct {
        lane_mask_t mask;                // Lanes that offer a fresh word
        logic       pop;
        int         reps;
    } stim_row_t;

    logic       clk;
    logic       rst_n;
    lane_mask_t lane_valid;
    lane_bus_t  lane_data;
    logic       pop;
    lane_mask_t lane_ready;
    data_t      pop_data;
    logic       full;
    logic       empty;
    occ_t       occupancy;

    stim_row_t  stim_table [N_ROWS];
    data_t      model_q [$];             // Expected contents, head first
    logic       held [LANES];            // Producer still owns an unaccepted word
    data_t      held_data [LANES];
    int         seed = 2242;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    // Scenario counters
    int         n_full = 0;
    int         n_partial = 0;           // Some valid lane held back by space
    int         n_pop_multi = 0;         // Pop plus two or more inserts
    int         n_empty_pop = 0;
    int         n_written = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    multi_insert_queue_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_valid),
        .lane_data  (lane_data),
        .lane_ready (lane_ready),
        .pop        (pop),
        .pop_data   (pop_data),
        .full       (full),
        .empty      (empty),
        .occupancy  (occupancy)
    );

    task automatic load_table();
        // Sparse masks, lane order without gaps
        stim_table[0]  = '{4'b1010, 1'b0, 1};
        stim_table[1]  = '{4'b0110, 1'b0, 1};
        stim_table[2]  = '{4'b0000, 1'b1, 4};
        stim_table[3]  = '{4'b1001, 1'b0, 2};
        stim_table[4]  = '{4'b0000, 1'b1, 4};
        // Fill to 16, back-pressure, held words drain in
        stim_table[5]  = '{4'b0001, 1'b0, 1};
        stim_table[6]  = '{4'b1111, 1'b0, 5};
        stim_table[7]  = '{4'b0000, 1'b1, 1};
        stim_table[8]  = '{4'b0000, 1'b0, 1};
        stim_table[9]  = '{4'b0000, 1'b1, 3};
        stim_table[10] = '{4'b0000, 1'b1, 2};
        // Pop together with multi-lane inserts, pointers wrap
        stim_table[11] = '{4'b0000, 1'b1, 10};
        stim_table[12] = '{4'b1111, 1'b1, 8};
        stim_table[13] = '{4'b1101, 1'b1, 6};
        // Drain, pop on empty, then insert again
        stim_table[14] = '{4'b0000, 1'b1, 24};
        stim_table[15] = '{4'b0000, 1'b1, 3};
        stim_table[16] = '{4'b0101, 1'b0, 2};
        stim_table[17] = '{4'b0000, 1'b1, 6};
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    // Lane g may go when fewer than free words would sit below it
    function automatic lane_mask_t ready_mask(input int free);
        lane_mask_t m;
        m = '0;
        for (int g = 0; g < LANES; g++) begin
            m[g] = (g < free);
        end
        return m;
    endfunction

    function automatic bit any_held();
        bit h;
        h = 1'b0;
        for (int g = 0; g < LANES; g++) begin
            h = h | held[g];
        end
        return h;
    endfunction

    // Producers keep an unaccepted word until their lane takes it
    task automatic drive_inputs(input lane_mask_t mask, input logic pop_bit);
        for (int g = 0; g < LANES; g++) begin
            if (!held[g] && mask[g]) begin
                held_data[g] = data_t'($random(seed));
                held[g]      = 1'b1;
            end
            lane_valid[g] = held[g];
            if (held[g]) begin
                lane_data[g*WIDTH +: WIDTH] = held_data[g];
            end else begin
                lane_data[g*WIDTH +: WIDTH] = data_t'($random(seed));  // Junk
            end
        end
        pop = pop_bit;
    endtask

    // Reference queue, one rising edge
    task automatic update_model();
        int free;
        int accepted;
        bit popped;
        free     = DEPTH - model_q.size();  // Space seen before any pop
        accepted = 0;
        popped   = 1'b0;
        if (pop && model_q.size() == 0) begin
            n_empty_pop++;
        end
        if (pop && model_q.size() > 0) begin
            void'(model_q.pop_front());
            popped = 1'b1;
        end
        for (int g = 0; g < LANES; g++) begin
            if (lane_valid[g] && g < free) begin
                model_q.push_back(lane_data[g*WIDTH +: WIDTH]);
                held[g] = 1'b0;
                accepted++;
            end else if (lane_valid[g] && free > 0) begin
                n_partial++;
            end
        end
        n_written += accepted;
        if (popped && accepted >= 2) begin
            n_pop_multi++;
        end
        if (model_q.size() == DEPTH) begin
            n_full++;
        end
    endtask

    task automatic check_outputs();
        int exp_size;
        exp_size = model_q.size();
        check_value("occupancy", occupancy, exp_size);
        check_value("empty", empty, exp_size == 0);
        check_value("full", full, exp_size == DEPTH);
        check_value("lane_ready", lane_ready, ready_mask(DEPTH - exp_size));
        if (exp_size > 0) begin
            check_value("pop_data", pop_data, model_q[0]);  // Head word
        end
    endtask

    task automatic check_assertions();
        if (u_dut.u_chk.fail_count != 0) begin
            $display("Checker assertion failed at time %0t", $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "Assertion failure in the bound checker");
        end
    endtask

    task automatic check_reset_state();
        check_value("empty", empty, 1'b1);
        check_value("full", full, 1'b0);
        check_value("occupancy", occupancy, 0);
        check_value("lane_ready", lane_ready, {LANES{1'b1}});
    endtask

    task automatic run_cycle(input lane_mask_t mask, input logic pop_bit);
        drive_inputs(mask, pop_bit);
        @(posedge clk);
        update_model();
        #(DRIVE_DELAY);
        check_outputs();
        check_assertions();
    endtask

    // Scenarios the table must have reached
    function automatic int coverage_holes();
        int holes;
        holes = 0;
        if (n_full == 0) begin
            $display("The queue never reached 16 words");
            holes++;
        end
        if (n_partial == 0) begin
            $display("No lane was ever held back by a nearly full queue");
            holes++;
        end
        if (n_pop_multi == 0) begin
            $display("No pop coincided with a multi-lane insert");
            holes++;
        end
        if (n_empty_pop == 0) begin
            $display("No pop was issued on an empty queue");
            holes++;
        end
        if (n_written <= DEPTH) begin
            $display("The pointers never wrapped around");
            holes++;
        end
        return holes;
    endfunction

    // Run limit from the table length
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout: the run went past %0d cycles", cycle_limit);
                $display("SOME TESTS FAILED");
                $fatal(1, "Timeout");
            end
        end
    end

    initial begin
        int total;
        int holes;
        lane_valid = '0;
        lane_data  = '0;
        pop        = 1'b0;
        for (int g = 0; g < LANES; g++) begin
            held[g]      = 1'b0;
            held_data[g] = '0;
        end
        load_table();
        total = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += stim_table[r].reps;
        end
        cycle_limit = total + TIMEOUT_PAD;

        wait (rst_n === 1'b1);
        check_reset_state();

        for (int r = 0; r < N_ROWS; r++) begin
            for (int k = 0; k < stim_table[r].reps; k++) begin
                run_cycle(stim_table[r].mask, stim_table[r].pop);
            end
        end

        // Consumer empties whatever is left
        while (model_q.size() != 0 || any_held()) begin
            run_cycle('0, 1'b1);
        end
        pop = 1'b0;

        holes = coverage_holes();
        if (holes == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Run ended with %0d scenario gaps", holes);
            $display("SOME TESTS FAILED");
            $fatal(1, "Scenario coverage incomplete");
        end
    end

endmodule

/* all.f */
+incdir+.
miq_pkg.sv
lane_packer.sv
insert_queue.sv
multi_insert_queue_top.sv
tb_clk_gen.sv
multi_insert_queue_chk.sv
multi_insert_queue_tb.sv
